/* hdl/bf16_block_pkg.sv */
package bf16_block_pkg;

    // --------------------------------------------------
    // BF16 field types
    // --------------------------------------------------

    // One BF16 word, sign on top
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [6:0] mantissa;
    } bf16_t;

    // Biased exponent field alone
    typedef logic [7:0] bf16_exp_t;

    // Quantized lane in two's complement
    typedef logic signed [7:0] q8_t;

    // --------------------------------------------------
    // Command opcodes
    // --------------------------------------------------

    // Codes 2 and 3 are illegal
    typedef enum logic [1:0] {
        BLK_OP_MAX   = 2'd0,
        BLK_OP_QUANT = 2'd1
    } blk_op_e;

    // Exponent of Inf and NaN
    localparam bf16_exp_t BF16_EXP_SPECIAL = 8'hFF;

    // Right shift at which a lane is all gone
    localparam int Q8_SHIFT_LIMIT = 8;

endpackage : bf16_block_pkg

/* hdl/bf16_block_if.sv */
// --------------------------------------------------
// Decode to execute
// --------------------------------------------------

interface blk_dec_if import bf16_block_pkg::*; #(
    parameter int NUM_INPUTS = 8
);
    // High for one cycle per command
    logic                   valid;
    blk_op_e                op;
    logic                   bad_op;
    // Lane 0 in the low word, zeroed on bad_op
    bf16_t [NUM_INPUTS-1:0] values;

    modport source (output valid, output op, output bad_op, output values);
    modport sink   (input valid, input op, input bad_op, input values);
endinterface : blk_dec_if

// --------------------------------------------------
// Execute to result
// --------------------------------------------------

interface blk_exe_if import bf16_block_pkg::*; #(
    parameter int NUM_INPUTS = 8
);
    localparam int IDX_W = $clog2(NUM_INPUTS);

    logic                   valid;
    blk_op_e                op;
    logic                   bad_op;
    bf16_t [NUM_INPUTS-1:0] values;
    // Winner of the max tree
    bf16_t                  max;
    logic [IDX_W-1:0]       max_index;
    // Block scale, zero for an all-zero block
    bf16_exp_t              shared_exp;
    logic                   all_zero;
    // Shared exponent is Inf/NaN
    logic                   special;

    modport source (output valid, output op, output bad_op, output values, output max,
                    output max_index, output shared_exp, output all_zero, output special);
    modport sink   (input valid, input op, input bad_op, input values, input max,
                    input max_index, input shared_exp, input all_zero, input special);
endinterface : blk_exe_if

/* hdl/bf16_block_decode.sv */
module bf16_block_decode import bf16_block_pkg::*; #(
    parameter int NUM_INPUTS = 8
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_start,
    input  logic [1:0]              i_op,
    input  logic [NUM_INPUTS*16-1:0] i_values_flat,
    blk_dec_if.source               dec
);

    // --------------------------------------------------
    // Opcode check
    // --------------------------------------------------

    blk_op_e w_op;
    logic    w_legal;

    // Raw code kept even when illegal
    assign w_op = blk_op_e'(i_op);

    // Only two codes mean anything
    assign w_legal = (w_op == BLK_OP_MAX) || (w_op == BLK_OP_QUANT);

    // --------------------------------------------------
    // Command register
    // --------------------------------------------------

    // One cycle strobe follows i_start
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            dec.valid  <= 1'b0;
            dec.op     <= BLK_OP_MAX;
            dec.bad_op <= 1'b0;
        end else begin
            dec.valid <= i_start;
            if (i_start) begin
                dec.op     <= w_op;
                dec.bad_op <= !w_legal;
            end
        end
    end

    // Block captured only with a command
    // Illegal command leaves a clean zero block behind
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            dec.values <= w_legal ? i_values_flat : '0;
        end
    end

endmodule : bf16_block_decode

/* hdl/math_bf16_max_tree.sv */
module math_bf16_max_tree import bf16_block_pkg::*; #(
    parameter int NUM_INPUTS = 8
) (
    input  logic [NUM_INPUTS*16-1:0]      i_values_flat,
    output logic [15:0]                   ow_max,
    output logic [$clog2(NUM_INPUTS)-1:0] ow_max_index,
    output logic                          ow_all_zero
);

    // --------------------------------------------------
    // Tree geometry
    // --------------------------------------------------

    localparam int NUM_LEVELS = $clog2(NUM_INPUTS);
    localparam int IDX_W      = $clog2(NUM_INPUTS);

    // Leaves plus comparators, a full binary tree
    localparam int NUM_NODES  = 2*NUM_INPUTS - 1;

    // Root sits in the last slot
    localparam int ROOT       = NUM_NODES - 1;

    // Node layout, level by level
    // Leaves in 0 .. N-1, level 1 from N, level 2 from N + N/2 and so on
    // Start of level l is 2N - (2N >> l)
    bf16_t            node_val [NUM_NODES];
    logic [IDX_W-1:0] node_idx [NUM_NODES];

    // --------------------------------------------------
    // Leaves and zero detect
    // --------------------------------------------------

    logic [NUM_INPUTS-1:0] w_lane_zero;

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : gen_leaf
        // Lane i from its 16 bit slot
        assign node_val[i] = i_values_flat[i*16 +: 16];
        assign node_idx[i] = IDX_W'(i);

        // Exponent zero counts as zero
        // so subnormals fall in here too
        assign w_lane_zero[i] = (node_val[i].exponent == 8'h00);
    end

    assign ow_all_zero = &w_lane_zero;

    // --------------------------------------------------
    // Comparator levels
    // --------------------------------------------------

    for (genvar lvl = 0; lvl < NUM_LEVELS; lvl++) begin : gen_level
        // First source node of this level
        localparam int SRC   = 2*NUM_INPUTS - ((2*NUM_INPUTS) >> lvl);
        // First node of the next level
        localparam int DST   = 2*NUM_INPUTS - (NUM_INPUTS >> lvl);
        // Comparators at this level
        localparam int NODES = NUM_INPUTS >> (lvl + 1);

        for (genvar n = 0; n < NODES; n++) begin : gen_node
            bf16_t       w_a;
            bf16_t       w_b;
            logic        w_a_nan;
            logic        w_b_nan;
            logic [14:0] w_a_mag;
            logic [14:0] w_b_mag;
            logic        w_a_sel;

            // Lower index on side a
            assign w_a = node_val[SRC + 2*n];
            assign w_b = node_val[SRC + 2*n + 1];

            // NaN needs all ones exponent and some mantissa
            assign w_a_nan = (w_a.exponent == BF16_EXP_SPECIAL) && (w_a.mantissa != 7'h00);
            assign w_b_nan = (w_b.exponent == BF16_EXP_SPECIAL) && (w_b.mantissa != 7'h00);

            // Sign dropped for magnitude
            assign w_a_mag = {w_a.exponent, w_a.mantissa};
            assign w_b_mag = {w_b.exponent, w_b.mantissa};

            // NaN on side a wins first
            // then NaN on side b, then magnitude
            // Equal magnitudes keep side a, the lower index
            assign w_a_sel = w_a_nan || (!w_b_nan && (w_a_mag >= w_b_mag));

            assign node_val[DST + n] = w_a_sel ? w_a : w_b;
            assign node_idx[DST + n] = w_a_sel ? node_idx[SRC + 2*n]
                                               : node_idx[SRC + 2*n + 1];
        end
    end

    // --------------------------------------------------
    // Root
    // --------------------------------------------------

    assign ow_max       = node_val[ROOT];
    assign ow_max_index = node_idx[ROOT];

endmodule : math_bf16_max_tree

/* hdl/bf16_block_execute.sv */
module bf16_block_execute import bf16_block_pkg::*; #(
    parameter int NUM_INPUTS = 8
) (
    input  logic      i_clk,
    input  logic      i_reset,
    blk_dec_if.sink   dec,
    blk_exe_if.source exe
);

    localparam int IDX_W = $clog2(NUM_INPUTS);

    bf16_t            w_max;
    logic [IDX_W-1:0] w_max_index;
    logic             w_all_zero;
    bf16_exp_t        w_shared_exp;

    // --------------------------------------------------
    // Max search over the decoded block
    // --------------------------------------------------

    math_bf16_max_tree #(
        .NUM_INPUTS    (NUM_INPUTS)
    ) u_max_tree (
        .i_values_flat (dec.values),
        .ow_max        (w_max),
        .ow_max_index  (w_max_index),
        .ow_all_zero   (w_all_zero)
    );

    // Scale taken from the winner
    // Forced to zero for an all-zero block
    assign w_shared_exp = w_all_zero ? 8'h00 : w_max.exponent;

    // --------------------------------------------------
    // Stage register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            exe.valid    <= 1'b0;
            exe.op       <= BLK_OP_MAX;
            exe.bad_op   <= 1'b0;
            exe.all_zero <= 1'b0;
            exe.special  <= 1'b0;
        end else begin
            exe.valid <= dec.valid;
            if (dec.valid) begin
                exe.op       <= dec.op;
                exe.bad_op   <= dec.bad_op;
                exe.all_zero <= w_all_zero;
                // Inf or NaN at the top of the block
                exe.special  <= (w_shared_exp == BF16_EXP_SPECIAL);
            end
        end
    end

    // Block and tree results move with the command
    always_ff @(posedge i_clk) begin
        if (dec.valid) begin
            exe.values     <= dec.values;
            exe.max        <= w_max;
            exe.max_index  <= w_max_index;
            exe.shared_exp <= w_shared_exp;
        end
    end

endmodule : bf16_block_execute

/* hdl/bf16_block_result.sv */
module bf16_block_result import bf16_block_pkg::*; #(
    parameter int NUM_INPUTS = 8
) (
    input  logic                           i_clk,
    input  logic                           i_reset,
    blk_exe_if.sink                        exe,
    output logic                           o_done,
    output logic                           o_bad_op,
    output blk_op_e                        o_op,
    output bf16_t                          o_max,
    output logic [$clog2(NUM_INPUTS)-1:0]  o_max_index,
    output bf16_exp_t                      o_shared_exp,
    output logic                           o_all_zero,
    output logic                           o_special,
    output logic [NUM_INPUTS*8-1:0]        o_quant_flat
);

    logic                   w_quant_en;
    q8_t [NUM_INPUTS-1:0]   w_quant;

    // Lanes switch only for a quantize with a finite scale
    assign w_quant_en = exe.valid && (exe.op == BLK_OP_QUANT) && !exe.special;

    // --------------------------------------------------
    // Lane quantizers
    // --------------------------------------------------

    for (genvar i = 0; i < NUM_INPUTS; i++) begin : gen_lane
        bf16_t      w_lane;
        logic [7:0] w_sig;
        logic [8:0] w_shift;
        logic [7:0] w_mag;

        // Operand isolation, lane held at zero when idle
        assign w_lane = w_quant_en ? exe.values[i] : '0;

        // Hidden one restored
        // Zero or subnormal gives no significand
        assign w_sig = (w_lane.exponent == 8'h00) ? 8'h00 : {1'b1, w_lane.mantissa};

        // Distance below the shared exponent, plus one for the sign bit
        // Never negative, the max holds the largest exponent
        assign w_shift = {1'b0, exe.shared_exp} - {1'b0, w_lane.exponent} + 9'd1;

        // Truncation toward zero
        // Only the low three shift bits matter below the limit
        assign w_mag = (w_shift >= 9'(Q8_SHIFT_LIMIT)) ? 8'h00 : (w_sig >> w_shift[2:0]);

        // Magnitude tops out at 127 so negation always fits
        assign w_quant[i] = w_lane.sign ? q8_t'(-w_mag) : q8_t'(w_mag);
    end

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------

    // Done follows valid, results hold until the next one
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_done       <= 1'b0;
            o_bad_op     <= 1'b0;
            o_op         <= BLK_OP_MAX;
            o_max        <= '0;
            o_max_index  <= '0;
            o_shared_exp <= '0;
            o_all_zero   <= 1'b0;
            o_special    <= 1'b0;
            o_quant_flat <= '0;
        end else begin
            o_done <= exe.valid;
            if (exe.valid) begin
                o_bad_op     <= exe.bad_op;
                o_op         <= exe.op;
                o_max        <= exe.max;
                o_max_index  <= exe.max_index;
                o_shared_exp <= exe.shared_exp;
                o_all_zero   <= exe.all_zero;
                o_special    <= exe.special;
                // Zero for max-only and special blocks
                o_quant_flat <= w_quant;
            end
        end
    end

endmodule : bf16_block_result

/* hdl/bf16_block_scaler.sv */
module bf16_block_scaler #(
    parameter int NUM_INPUTS = 8
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    // Command in
    input  logic                          i_start,
    input  logic [1:0]                    i_op,
    input  logic [NUM_INPUTS*16-1:0]      i_values_flat,
    // Result out, three stages later
    output logic                          o_done,
    output logic                          o_bad_op,
    output logic [1:0]                    o_op,
    output logic [15:0]                   o_max,
    output logic [$clog2(NUM_INPUTS)-1:0] o_max_index,
    output logic [7:0]                    o_shared_exp,
    output logic                          o_all_zero,
    output logic                          o_special,
    output logic [NUM_INPUTS*8-1:0]       o_quant_flat
);

    // --------------------------------------------------
    // Stage links
    // --------------------------------------------------

    blk_dec_if #(.NUM_INPUTS(NUM_INPUTS)) dec_if ();
    blk_exe_if #(.NUM_INPUTS(NUM_INPUTS)) exe_if ();

    // --------------------------------------------------
    // Pipeline
    // --------------------------------------------------

    // Stage 1, command capture
    bf16_block_decode #(
        .NUM_INPUTS    (NUM_INPUTS)
    ) u_decode (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_op          (i_op),
        .i_values_flat (i_values_flat),
        .dec           (dec_if.source)
    );

    // Stage 2, max search and scale
    bf16_block_execute #(
        .NUM_INPUTS (NUM_INPUTS)
    ) u_execute (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .dec        (dec_if.sink),
        .exe        (exe_if.source)
    );

    // Stage 3, quantize and hold
    bf16_block_result #(
        .NUM_INPUTS   (NUM_INPUTS)
    ) u_result (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .exe          (exe_if.sink),
        .o_done       (o_done),
        .o_bad_op     (o_bad_op),
        .o_op         (o_op),
        .o_max        (o_max),
        .o_max_index  (o_max_index),
        .o_shared_exp (o_shared_exp),
        .o_all_zero   (o_all_zero),
        .o_special    (o_special),
        .o_quant_flat (o_quant_flat)
    );

endmodule : bf16_block_scaler

/* sim/tb_bf16_ref.svh */
`ifndef TB_BF16_REF_SVH
`define TB_BF16_REF_SVH

// --------------------------------------------------
// Expected result of one command
// --------------------------------------------------

typedef struct packed {
    logic [1:0]           op;
    logic                 bad_op;
    bf16_t                max;
    logic [IDX_W-1:0]     max_index;
    bf16_exp_t            shared_exp;
    logic                 all_zero;
    logic                 special;
    q8_t [NUM_INPUTS-1:0] quant;
} result_t;

function automatic logic is_nan(input bf16_t v);
    return (v.exponent == 8'hFF) && (v.mantissa != 7'h00);
endfunction

// Behavioral model of a whole command
function automatic result_t ref_block(input logic [1:0] op,
                                      input logic [NUM_INPUTS*16-1:0] flat);
    result_t                  r;
    logic [NUM_INPUTS*16-1:0] blk;
    bf16_t                    lane;
    bf16_t                    best;
    int                       shift;
    int                       mag;
    r        = '0;
    r.op     = op;
    r.bad_op = (op != 2'd0) && (op != 2'd1);
    // Illegal command runs on an all-zero block
    blk      = r.bad_op ? '0 : flat;
    best     = blk[15:0];
    r.all_zero = 1'b1;
    for (int i = 0; i < NUM_INPUTS; i++) begin
        lane = blk[i*16 +: 16];
        if (lane.exponent != 8'h00) begin
            r.all_zero = 1'b0;
        end
        // Lowest NaN sticks, else strictly larger magnitude takes over
        if (i > 0 && !is_nan(best) && (is_nan(lane) || lane[14:0] > best[14:0])) begin
            best        = lane;
            r.max_index = IDX_W'(i);
        end
    end
    r.max        = best;
    r.shared_exp = r.all_zero ? 8'h00 : best.exponent;
    r.special    = (r.shared_exp == 8'hFF);
    // Quantize by truncation toward zero
    if (op == 2'd1 && !r.special) begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            lane  = blk[i*16 +: 16];
            shift = int'(r.shared_exp) - int'(lane.exponent) + 1;
            if (lane.exponent == 8'h00 || shift >= 8) begin
                mag = 0;
            end else begin
                mag = (128 + int'(lane.mantissa)) >> shift;
            end
            r.quant[i] = lane.sign ? q8_t'(-mag) : q8_t'(mag);
        end
    end
    return r;
endfunction

// --------------------------------------------------
// Typed compares
// --------------------------------------------------

task automatic check_bf16(input string name, input bf16_t exp_v, input bf16_t act_v);
    if (act_v !== exp_v) begin
        fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
    end
endtask

task automatic check_exp(input string name, input bf16_exp_t exp_v, input bf16_exp_t act_v);
    if (act_v !== exp_v) begin
        fail_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_v, act_v));
    end
endtask

task automatic check_q8(input string name, input q8_t exp_v, input q8_t act_v);
    if (act_v !== exp_v) begin
        fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v));
    end
endtask

task automatic check_index(input string name, input logic [IDX_W-1:0] exp_v,
                           input logic [IDX_W-1:0] act_v);
    if (act_v !== exp_v) begin
        fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v));
    end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        fail_run($sformatf("MISMATCH %s expected %b actual %b", name, exp_v, act_v));
    end
endtask

task automatic check_op(input string name, input blk_op_e exp_v, input blk_op_e act_v);
    if (act_v !== exp_v) begin
        fail_run($sformatf("MISMATCH %s expected %0d actual %0d", name, exp_v, act_v));
    end
endtask

`endif

/* sim/tb_bf16_block_scaler.sv */
module tb_bf16_block_scaler import bf16_block_pkg::*;;

    localparam int NUM_INPUTS = 8;
    localparam int IDX_W      = $clog2(NUM_INPUTS);

    logic                          i_clk;
    logic                          i_reset;
    logic                          i_start;
    logic [1:0]                    i_op;
    logic [NUM_INPUTS*16-1:0]      i_values_flat;
    logic                          o_done;
    logic                          o_bad_op;
    logic [1:0]                    o_op;
    logic [15:0]                   o_max;
    logic [IDX_W-1:0]              o_max_index;
    logic [7:0]                    o_shared_exp;
    logic                          o_all_zero;
    logic                          o_special;
    logic [NUM_INPUTS*8-1:0]       o_quant_flat;

    integer seed = 36;
    int     cycle;
    int     start_q [$];
    string  name_q [$];

    `include "tb_bf16_ref.svh"

    result_t exp_q [$];

    bf16_block_scaler #(
        .NUM_INPUTS    (NUM_INPUTS)
    ) dut_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_op          (i_op),
        .i_values_flat (i_values_flat),
        .o_done        (o_done),
        .o_bad_op      (o_bad_op),
        .o_op          (o_op),
        .o_max         (o_max),
        .o_max_index   (o_max_index),
        .o_shared_exp  (o_shared_exp),
        .o_all_zero    (o_all_zero),
        .o_special     (o_special),
        .o_quant_flat  (o_quant_flat)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // --------------------------------------------------
    // Output compare against one record
    // --------------------------------------------------

    task automatic compare_outputs(input string nm, input result_t e);
        check_flag({nm, " bad_op"}, e.bad_op, o_bad_op);
        check_op({nm, " op"}, blk_op_e'(e.op), blk_op_e'(o_op));
        check_bf16({nm, " max"}, e.max, o_max);
        check_index({nm, " max_index"}, e.max_index, o_max_index);
        check_exp({nm, " shared_exp"}, e.shared_exp, o_shared_exp);
        check_flag({nm, " all_zero"}, e.all_zero, o_all_zero);
        check_flag({nm, " special"}, e.special, o_special);
        for (int i = 0; i < NUM_INPUTS; i++) begin
            check_q8($sformatf("%s lane %0d", nm, i), e.quant[i], q8_t'(o_quant_flat[i*8 +: 8]));
        end
    endtask

    // Edge counter, start log and result check
    // Values read here are the ones the DUT sees at this edge
    initial begin : compare_proc
        int      s;
        result_t e;
        string   nm;
        cycle = 0;
        forever begin
            @(posedge i_clk);
            cycle++;
            if (i_start === 1'b1 && i_reset === 1'b0) begin
                start_q.push_back(cycle);
            end
            if (o_done === 1'b1) begin
                if (start_q.size() == 0 || exp_q.size() == 0) begin
                    fail_run("done pulse arrived with no command pending");
                end
                s  = start_q.pop_front();
                e  = exp_q.pop_front();
                nm = name_q.pop_front();
                if (cycle - s != 3) begin
                    fail_run($sformatf("%s done came %0d cycles after start", nm, cycle - s));
                end
                compare_outputs(nm, e);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------

    task automatic send(input string nm, input logic [1:0] op,
                        input logic [NUM_INPUTS*16-1:0] flat);
        @(posedge i_clk);
        i_start       <= 1'b1;
        i_op          <= op;
        i_values_flat <= flat;
        exp_q.push_back(ref_block(op, flat));
        name_q.push_back(nm);
    endtask

    // Drop start and wait out every pending result
    task automatic drain(input string what);
        int waited;
        @(posedge i_clk);
        i_start <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge i_clk);
            waited++;
            if (waited > 20) begin
                fail_run($sformatf("done pulse never arrived during %s", what));
            end
        end
    endtask

    // Spread of exponents, some lanes far below, some zero
    function automatic logic [NUM_INPUTS*16-1:0] rand_block();
        logic [NUM_INPUTS*16-1:0] flat;
        logic [31:0]              r;
        bf16_t                    v;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            r          = $random(seed);
            v.sign     = r[0];
            v.exponent = 8'd110 + 8'(r[5:1]);
            if (r[7:6] == 2'b00) begin
                v.exponent = v.exponent - 8'd12;
            end
            if (r[20:18] == 3'b000) begin
                v.exponent = 8'h00;
            end
            v.mantissa       = r[14:8];
            flat[i*16 +: 16] = v;
        end
        return flat;
    endfunction

    task automatic check_reset_state(input string nm);
        check_flag({nm, " done"}, 1'b0, o_done);
        compare_outputs(nm, result_t'(0));
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin : stimulus
        logic [1:0] op;
        i_reset       = 1'b1;
        i_start       = 1'b0;
        i_op          = 2'd0;
        i_values_flat = '0;
        for (int k = 0; k < 5; k++) begin
            @(posedge i_clk);
            if (k > 0) begin
                check_reset_state("reset");
            end
        end
        i_reset <= 1'b0;
        @(posedge i_clk);
        check_reset_state("after reset");

        // Lanes listed 7 down to 0
        send("max negative", 2'd0, {16'h3E00, 16'h4000, 16'h3F00, 16'hC100,
                                    16'hBF00, 16'h4080, 16'hC040, 16'h3F80});
        drain("max negative");
        send("max tie", 2'd0, {16'h3F80, 16'h3E00, 16'hC0A0, 16'h3F00,
                               16'hBF80, 16'h40A0, 16'h4000, 16'h3F80});
        drain("max tie");

        // Inf at lane 1, NaNs at lanes 3 and 6
        // Lane 6 NaN has the larger magnitude, lane 3 must still win
        send("nan inf", 2'd1, {16'h3F80, 16'h7FFF, 16'h4000, 16'hC000,
                               16'hFFC1, 16'h3F00, 16'h7F80, 16'hBF80});
        drain("nan inf");
        send("zeros subnormals", 2'd1, {16'h0000, 16'h007F, 16'h807F, 16'h0003,
                                        16'h8000, 16'h0001, 16'h0040, 16'h0000});
        drain("zeros subnormals");

        for (int n = 0; n < 40; n++) begin
            send($sformatf("quant %0d", n), 2'd1, rand_block());
            drain("random quant");
        end

        send("illegal op 2", 2'd2, rand_block());
        drain("illegal op 2");
        send("illegal op 3", 2'd3, rand_block());
        drain("illegal op 3");

        // Consecutive starts with mixed opcodes
        for (int n = 0; n < 16; n++) begin
            op = 2'($random(seed));
            send($sformatf("burst %0d", n), op, rand_block());
        end
        drain("burst");

        repeat (3) @(posedge i_clk);
        $display("All tests passed!");
        $finish;
    end

endmodule : tb_bf16_block_scaler

/* compile.f */
+incdir+sim
hdl/bf16_block_pkg.sv
hdl/bf16_block_if.sv
hdl/bf16_block_decode.sv
hdl/math_bf16_max_tree.sv
hdl/bf16_block_execute.sv
hdl/bf16_block_result.sv
hdl/bf16_block_scaler.sv
sim/tb_bf16_block_scaler.sv
